// File: flist.f
src/rv_isa_pkg.sv
src/core_pipe_pkg.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/rv_exec_core.sv
sim/rv_exec_core_chk.sv
sim/rv_exec_core_tb.sv

// File: sim/rv_exec_core_chk.sv
`timescale 1ns/10ps

module rv_exec_core_chk (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   in_valid,
  input logic                   in_ready,
  input logic                   ret_valid,
  input logic                   ret_ready,
  input core_pipe_pkg::retire_t ret
);

  int          fail_cnt = 0;
  int unsigned in_flight;  // accepted, not yet retired

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + 32'(in_valid && in_ready) - 32'(ret_valid && ret_ready);
    end
  end

  idle_after_reset_a: assert property (@(posedge clk) $rose(rst_n) |-> !ret_valid && in_ready)
    else begin
      $error("core not idle when reset was released");
      fail_cnt++;
    end

  // nothing retires unless something went in
  no_spurious_a: assert property (@(posedge clk) disable iff (!rst_n)
    ret_valid |-> in_flight != 0)
    else begin
      $error("ret_valid high with no instruction in flight");
      fail_cnt++;
    end

  max_in_flight_a: assert property (@(posedge clk) disable iff (!rst_n) in_flight <= 3)
    else begin
      $error("more than three instructions in flight");
      fail_cnt++;
    end

  hold_while_stalled_a: assert property (@(posedge clk) disable iff (!rst_n)
    ret_valid && !ret_ready |=> ret_valid && $stable(ret))
    else begin
      $error("retire record changed while stalled");
      fail_cnt++;
    end

  // decode, execute, result with no back-pressure
  two_cycle_latency_a: assert property (@(posedge clk) disable iff (!rst_n)
    (in_valid && in_ready) ##1 ret_ready [*2] |=> ret_valid)
    else begin
      $error("ret_valid not high two cycles after acceptance");
      fail_cnt++;
    end

endmodule

bind rv_exec_core rv_exec_core_chk chk_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .in_ready  (in_ready),
  .ret_valid (ret_valid),
  .ret_ready (ret_ready),
  .ret       (ret)
);

// File: sim/rv_exec_core_tb.sv
`timescale 1ns/10ps

module rv_exec_core_tb;

  import rv_isa_pkg::*;
  import core_pipe_pkg::*;

  localparam int reset_ns = 16 * 20;
  // fill, r-type, immediate, chain, stall and x0 groups
  localparam int total_insts = 31 + 40 + 26 + 24 + 60 + 8;

  logic    clk;
  logic    rst_n;
  logic    in_valid;
  logic    in_ready;
  inst_u   in_inst;
  logic    ret_valid;
  logic    ret_ready;
  retire_t ret;

  int          seed;
  word_t       model [nregs];  // reference register file
  retire_t     exp_q [$];      // expected retires in program order
  retire_t     exp_ret;
  string       test_name;
  int          errors = 0;
  int          test_err0 = 0;
  int          sent = 0;
  int          retired = 0;
  int          tests_run = 0;
  logic        stall_on = 1'b0;
  logic [63:0] stall_pat = '1;
  int          pat_idx = 0;

  rv_exec_core dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_inst   (in_inst),
    .ret_valid (ret_valid),
    .ret_ready (ret_ready),
    .ret       (ret)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ret_ready follows the random pattern only during the stall test
  initial begin
    logic nxt;
    ret_ready = 1'b1;
    forever begin
      @(posedge clk);
      nxt = stall_on ? stall_pat[pat_idx % 64] : 1'b1;
      pat_idx++;
      #2;
      ret_ready = nxt;
    end
  end

  // handshake seen mid-cycle completes on the next rising edge
  always @(negedge clk) begin
    if (rst_n && ret_valid && ret_ready) begin
      if (exp_q.size() == 0) begin
        $display("retire seen in %s with no instruction outstanding", test_name);
        errors++;
      end else begin
        exp_ret = exp_q.pop_front();
        retired++;
        assert (ret === exp_ret) else begin
          $display("[ERROR] %s expected %h actual %h", test_name, exp_ret, ret);
          errors++;
        end
      end
    end
  end

  initial begin
    #(reset_ns + 20 * total_insts * 4);
    $display("run timed out with %0d retires still outstanding", exp_q.size());
    $display("tests failed");
    $finish;
  end

  function automatic int err_count();
    return errors + dut_i.chk_i.fail_cnt;
  endfunction

  function automatic word_t r_word(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                   logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic word_t i_word(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3, reg_idx_t rd);
    return {imm, rs1, f3, rd, opc_op_imm};
  endfunction

  // kind 0 r-type, 1 i-type, 2 any legal word
  function automatic word_t rand_inst(int kind);
    logic [31:0] rnd;
    logic [31:0] sel;
    logic [11:0] imm;
    logic [6:0]  f7;
    rnd = $random(seed);
    sel = $random(seed);
    if (kind == 2) kind = (sel[1:0] == 2'd3) ? 3 : int'(sel[0]);
    f7  = (rnd[31] && (rnd[14:12] == 3'd0 || rnd[14:12] == 3'd5)) ? funct7_alt : funct7_base;
    imm = rnd[31:20];
    if (rnd[14:12] == f3_sll) imm[11:5] = funct7_base;
    if (rnd[14:12] == f3_srl_sra) imm[11:5] = rnd[30] ? funct7_alt : funct7_base;
    case (kind)
      0:       return {f7, rnd[24:7], opc_op};
      1:       return {imm, rnd[19:7], opc_op_imm};
      default: return {rnd[31:7], opc_lui};
    endcase
  endfunction

  // executes one word on the register copy, gives the record it must retire with
  function automatic retire_t model_step(word_t w);
    retire_t    r;
    logic [6:0] opc;
    logic [6:0] f7;
    logic [2:0] f3;
    word_t      a;
    word_t      b;
    word_t      v;
    logic       bad;
    opc = w[6:0];
    f3  = w[14:12];
    f7  = w[31:25];
    a   = model[w[19:15]];
    b   = (opc == opc_op) ? model[w[24:20]] : {{20{w[31]}}, w[31:20]};
    case (opc)
      opc_op:     bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
      opc_op_imm: bad = (f3 == 3'd1 && f7 != 7'h00) ||
                        (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
      opc_lui:    bad = 1'b0;
      default:    bad = 1'b1;
    endcase
    case (f3)
      3'd0:    v = (opc == opc_op && f7[5]) ? a - b : a + b;
      3'd1:    v = a << b[4:0];
      3'd2:    v = {31'b0, $signed(a) < $signed(b)};
      3'd3:    v = {31'b0, a < b};
      3'd4:    v = a ^ b;
      3'd5:    v = f7[5] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    v = a | b;
      default: v = a & b;
    endcase
    if (opc == opc_lui) v = {w[31:12], 12'h000};
    r.rd      = w[11:7];
    r.wr_en   = !bad && (w[11:7] != 5'd0);
    r.value   = bad ? '0 : v;
    r.illegal = bad;
    r.inst    = w;
    if (r.wr_en) model[r.rd] = r.value;
    return r;
  endfunction

  // in_ready is settled mid-cycle, the transfer is on the next edge
  task automatic send_inst(word_t w);
    exp_q.push_back(model_step(w));
    sent++;
    in_valid = 1'b1;
    in_inst  = w;
    @(negedge clk);
    while (!in_ready) @(negedge clk);
    @(posedge clk);
    #2;
    in_valid = 1'b0;
  endtask

  task automatic begin_test(string name);
    test_name = name;
    test_err0 = err_count();
  endtask

  task automatic end_test();
    while (exp_q.size() != 0) @(negedge clk);
    @(posedge clk);
    #2;
    tests_run++;
    $display("test %s done, %0d errors", test_name, err_count() - test_err0);
  endtask

  initial begin
    word_t    w;
    reg_idx_t prev;
    reg_idx_t prev2;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_inst  = '0;
    seed     = 32'hadfa_db06;
    foreach (model[i]) model[i] = '0;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;

    begin_test("reset_idle");
    repeat (8) begin
      @(negedge clk);
      assert (!ret_valid && in_ready) else begin
        $display("[ERROR] %s expected ret_valid 0 in_ready 1 actual ret_valid %b in_ready %b",
                 test_name, ret_valid, in_ready);
        errors++;
      end
    end
    end_test();

    begin_test("alu_reg");
    for (int k = 1; k < 32; k++) begin
      send_inst(i_word(12'($random(seed)), 5'd0, f3_add_sub, 5'(k)));  // fill x1..x31
    end
    repeat (40) send_inst(rand_inst(0));
    end_test();

    begin_test("alu_imm");
    send_inst({20'h80000, 5'd1, opc_lui});
    send_inst(i_word(12'hfff, 5'd1, f3_add_sub, 5'd2));  // 0x7fffffff
    send_inst(i_word(12'h800, 5'd0, f3_add_sub, 5'd3));  // most negative imm
    send_inst(i_word({funct7_alt, 5'd4}, 5'd1, f3_srl_sra, 5'd4));
    send_inst(i_word({funct7_alt, 5'd31}, 5'd3, f3_srl_sra, 5'd5));
    send_inst(i_word(12'h000, 5'd1, f3_slt, 5'd6));
    send_inst(i_word(12'h800, 5'd3, f3_slt, 5'd7));      // equal operands
    send_inst(i_word(12'hfff, 5'd0, f3_sltu, 5'd8));
    send_inst(i_word(12'h7ff, 5'd2, f3_sltu, 5'd9));
    send_inst(i_word(12'hfff, 5'd2, f3_xor, 5'd10));
    repeat (16) send_inst(rand_inst(1));
    end_test();

    begin_test("fwd_chain");
    prev  = 5'd1;
    prev2 = 5'd2;
    repeat (24) begin
      w = rand_inst(0);
      if (w[11:7] == 5'd0) w[11:7] = 5'd31;
      w[19:15] = prev;   // one back
      w[24:20] = prev2;  // two back
      send_inst(w);
      prev2 = prev;
      prev  = w[11:7];
    end
    end_test();

    begin_test("ret_stall");
    stall_pat[31:0]  = $random(seed);
    stall_pat[63:32] = $random(seed);
    stall_on = 1'b1;
    repeat (60) begin
      send_inst(rand_inst(2));
      if (($random(seed) & 7) == 0) #20;  // idle gap in the stream
    end
    end_test();
    stall_on = 1'b0;

    begin_test("x0_illegal");
    send_inst(i_word(12'd5, 5'd1, f3_add_sub, 5'd0));
    send_inst(r_word(funct7_base, 5'd0, 5'd0, f3_or, 5'd11));  // x0 reads zero
    send_inst(r_word(funct7_base, 5'd2, 5'd1, f3_add_sub, 5'd0));
    send_inst({12'h000, 5'd1, 3'b010, 5'd7, 7'b0000011});      // lw
    send_inst(r_word(7'b0000001, 5'd2, 5'd1, f3_add_sub, 5'd8));
    send_inst(r_word(funct7_alt, 5'd2, 5'd1, f3_sll, 5'd9));
    send_inst(i_word({funct7_alt, 5'd3}, 5'd1, f3_sll, 5'd10));
    send_inst(r_word(funct7_base, 5'd0, 5'd7, f3_or, 5'd12));  // x7 untouched
    end_test();

    $display("summary: %0d tests, %0d sent, %0d retired, %0d errors",
             tests_run, sent, retired, err_count());
    if (err_count() == 0 && retired == sent) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: src/core_pipe_pkg.sv
package core_pipe_pkg;

  // the ten rv32i functions plus a pass of operand b for lui
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  // decode to execute
  typedef struct packed {
    alu_op_e              alu_op;
    rv_isa_pkg::word_t    op_a;
    rv_isa_pkg::word_t    op_b;    // register value or immediate
    rv_isa_pkg::reg_idx_t rd;
    logic                 wr_en;
    logic                 illegal;
    rv_isa_pkg::word_t    inst;    // raw word for tracing
  } decoded_t;

  // execute to result, also the forwarding payload
  typedef struct packed {
    rv_isa_pkg::reg_idx_t rd;
    logic                 wr_en;
    rv_isa_pkg::word_t    value;
    logic                 illegal;
    rv_isa_pkg::word_t    inst;
  } result_t;

  // record handed out at retire
  typedef result_t retire_t;

endpackage

// File: src/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid,
  output logic                    in_ready,
  input  rv_isa_pkg::inst_u       in_inst,
  input  logic                    ex_fwd_valid,
  input  core_pipe_pkg::result_t  ex_fwd,
  input  logic                    res_fwd_valid,
  input  core_pipe_pkg::result_t  res_fwd,
  output rv_isa_pkg::reg_idx_t    rf_idx_a,
  output rv_isa_pkg::reg_idx_t    rf_idx_b,
  input  rv_isa_pkg::word_t       rf_data_a,
  input  rv_isa_pkg::word_t       rf_data_b,
  output logic                    dec_valid,
  input  logic                    dec_ready,
  output core_pipe_pkg::decoded_t dec
);

  import rv_isa_pkg::*;
  import core_pipe_pkg::*;

  logic       slot_valid;
  inst_u      slot_inst;
  opcode_e    opc;
  logic [2:0] f3;
  logic [6:0] f7;
  alu_op_e    alu_op;
  word_t      imm;
  logic       use_imm;
  logic       illegal;
  word_t      opnd_a;
  word_t      opnd_b;

  assign in_ready = !slot_valid || dec_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_valid <= 1'b0;
    end else if (in_ready) begin
      slot_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      slot_inst <= in_inst;
    end
  end

  // field positions shared by all three formats
  assign opc      = slot_inst.r.opcode;
  assign f3       = slot_inst.r.funct3;
  assign f7       = slot_inst.r.funct7;  // upper imm bits on shift-immediates
  assign rf_idx_a = slot_inst.r.rs1;
  assign rf_idx_b = slot_inst.r.rs2;

  always_comb begin
    alu_op  = alu_add;
    imm     = '0;
    use_imm = 1'b1;
    illegal = 1'b0;
    case (opc)
      opc_op: begin
        use_imm = 1'b0;
        case (f3)
          f3_add_sub: alu_op = (f7 == funct7_alt) ? alu_sub : alu_add;
          f3_sll:     alu_op = alu_sll;
          f3_slt:     alu_op = alu_slt;
          f3_sltu:    alu_op = alu_sltu;
          f3_xor:     alu_op = alu_xor;
          f3_srl_sra: alu_op = (f7 == funct7_alt) ? alu_sra : alu_srl;
          f3_or:      alu_op = alu_or;
          default:    alu_op = alu_and;
        endcase
        // alt only legal on add/sub and srl/sra
        if (f7 == funct7_alt) begin
          illegal = (f3 != f3_add_sub) && (f3 != f3_srl_sra);
        end else begin
          illegal = (f7 != funct7_base);
        end
      end
      opc_op_imm: begin
        imm = {{(xlen - 12){slot_inst.i.imm[11]}}, slot_inst.i.imm};
        case (f3)
          f3_add_sub: alu_op = alu_add;
          f3_sll: begin
            alu_op  = alu_sll;
            illegal = (f7 != funct7_base);
          end
          f3_slt:     alu_op = alu_slt;
          f3_sltu:    alu_op = alu_sltu;
          f3_xor:     alu_op = alu_xor;
          f3_srl_sra: begin
            alu_op  = (f7 == funct7_alt) ? alu_sra : alu_srl;
            illegal = (f7 != funct7_base) && (f7 != funct7_alt);
          end
          f3_or:      alu_op = alu_or;
          default:    alu_op = alu_and;
        endcase
      end
      opc_lui: begin
        imm    = {slot_inst.u.imm, 12'b0};
        alu_op = alu_pass_b;
      end
      default: illegal = 1'b1;  // loads, branches and the rest
    endcase
  end

  // x0, then the younger stage, then the older one, then the file
  function automatic word_t fwd_sel(reg_idx_t idx, word_t rf_val);
    if (idx == '0) begin
      return '0;
    end
    if (ex_fwd_valid && ex_fwd.wr_en && (ex_fwd.rd == idx)) begin
      return ex_fwd.value;
    end
    if (res_fwd_valid && res_fwd.wr_en && (res_fwd.rd == idx)) begin
      return res_fwd.value;
    end
    return rf_val;
  endfunction

  always_comb begin
    opnd_a = fwd_sel(slot_inst.r.rs1, rf_data_a);
    opnd_b = fwd_sel(slot_inst.r.rs2, rf_data_b);
  end

  assign dec_valid = slot_valid;

  always_comb begin
    dec.alu_op  = alu_op;
    dec.op_a    = opnd_a;
    dec.op_b    = use_imm ? imm : opnd_b;
    dec.rd      = slot_inst.r.rd;
    dec.wr_en   = !illegal && (slot_inst.r.rd != '0);
    dec.illegal = illegal;
    dec.inst    = slot_inst;
  end

endmodule

// File: src/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    dec_valid,
  output logic                    dec_ready,
  input  core_pipe_pkg::decoded_t dec,
  output logic                    res_valid_in,
  input  logic                    res_ready,
  output core_pipe_pkg::result_t  ex_out
);

  import rv_isa_pkg::*;
  import core_pipe_pkg::*;

  logic     ex_valid;
  decoded_t ex_q;
  logic [4:0] shamt;
  word_t    alu_res;

  assign dec_ready = !ex_valid || res_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
    end else if (dec_ready) begin
      ex_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid && dec_ready) begin
      ex_q <= dec;
    end
  end

  assign shamt = ex_q.op_b[4:0];

  always_comb begin
    case (ex_q.alu_op)
      alu_add:    alu_res = ex_q.op_a + ex_q.op_b;
      alu_sub:    alu_res = ex_q.op_a - ex_q.op_b;
      alu_sll:    alu_res = ex_q.op_a << shamt;
      alu_slt:    alu_res = {{(xlen - 1){1'b0}}, $signed(ex_q.op_a) < $signed(ex_q.op_b)};
      alu_sltu:   alu_res = {{(xlen - 1){1'b0}}, ex_q.op_a < ex_q.op_b};
      alu_xor:    alu_res = ex_q.op_a ^ ex_q.op_b;
      alu_srl:    alu_res = ex_q.op_a >> shamt;
      alu_sra:    alu_res = $signed(ex_q.op_a) >>> shamt;
      alu_or:     alu_res = ex_q.op_a | ex_q.op_b;
      alu_and:    alu_res = ex_q.op_a & ex_q.op_b;
      alu_pass_b: alu_res = ex_q.op_b;  // lui
      default:    alu_res = '0;
    endcase
  end

  // also the forwarding source for decode
  assign res_valid_in = ex_valid;

  always_comb begin
    ex_out.rd      = ex_q.rd;
    ex_out.wr_en   = ex_q.wr_en;
    ex_out.value   = ex_q.illegal ? '0 : alu_res;
    ex_out.illegal = ex_q.illegal;
    ex_out.inst    = ex_q.inst;
  end

endmodule

// File: src/reg_file.sv
`timescale 1ns/10ps

module reg_file (
  input  logic                 clk,
  input  logic                 rst_n,
  input  rv_isa_pkg::reg_idx_t rd_idx_a,
  input  rv_isa_pkg::reg_idx_t rd_idx_b,
  output rv_isa_pkg::word_t    rd_data_a,
  output rv_isa_pkg::word_t    rd_data_b,
  input  logic                 wr_en,
  input  rv_isa_pkg::reg_idx_t wr_idx,
  input  rv_isa_pkg::word_t    wr_data
);

  import rv_isa_pkg::*;

  word_t regs [nregs];

  // x0 is never written so it reads back zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < nregs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_idx != '0)) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // combinational reads, forwarding covers in-flight writers
  assign rd_data_a = regs[rd_idx_a];
  assign rd_data_b = regs[rd_idx_b];

endmodule

// File: src/result_stage.sv
`timescale 1ns/10ps

module result_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   res_valid_in,
  output logic                   res_ready,
  input  core_pipe_pkg::result_t ex_out,
  output logic                   ret_valid,
  input  logic                   ret_ready,
  output core_pipe_pkg::retire_t ret,
  output logic                   wr_en,
  output rv_isa_pkg::reg_idx_t   wr_idx,
  output rv_isa_pkg::word_t      wr_data,
  output logic                   res_fwd_valid,
  output core_pipe_pkg::result_t res_fwd
);

  import core_pipe_pkg::*;

  logic    res_valid;
  result_t res_q;

  assign res_ready = !res_valid || ret_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else if (res_ready) begin
      res_valid <= res_valid_in;
    end
  end

  always_ff @(posedge clk) begin
    if (res_valid_in && res_ready) begin
      res_q <= ex_out;
    end
  end

  assign ret_valid = res_valid;
  assign ret       = res_q;

  // register write lands on the retire edge
  assign wr_en   = res_valid && ret_ready && res_q.wr_en;
  assign wr_idx  = res_q.rd;
  assign wr_data = res_q.value;

  assign res_fwd_valid = res_valid;
  assign res_fwd       = res_q;  // held until retire, so still forwarded while stalled

endmodule

// File: src/rv_exec_core.sv
`timescale 1ns/10ps

module rv_exec_core (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  rv_isa_pkg::inst_u      in_inst,
  output logic                   ret_valid,
  input  logic                   ret_ready,
  output core_pipe_pkg::retire_t ret
);

  import rv_isa_pkg::*;
  import core_pipe_pkg::*;

  // decode to execute
  logic     dec_valid;
  logic     dec_ready;
  decoded_t dec;

  // execute to result, doubles as the younger forwarding path
  logic     res_valid_in;
  logic     res_ready;
  result_t  ex_out;

  logic     res_fwd_valid;
  result_t  res_fwd;

  // register file ports
  reg_idx_t rf_idx_a;
  reg_idx_t rf_idx_b;
  word_t    rf_data_a;
  word_t    rf_data_b;
  logic     rf_wr_en;
  reg_idx_t rf_wr_idx;
  word_t    rf_wr_data;

  decode_stage decode_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .in_inst       (in_inst),
    .ex_fwd_valid  (res_valid_in),
    .ex_fwd        (ex_out),
    .res_fwd_valid (res_fwd_valid),
    .res_fwd       (res_fwd),
    .rf_idx_a      (rf_idx_a),
    .rf_idx_b      (rf_idx_b),
    .rf_data_a     (rf_data_a),
    .rf_data_b     (rf_data_b),
    .dec_valid     (dec_valid),
    .dec_ready     (dec_ready),
    .dec           (dec)
  );

  execute_stage execute_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .dec_valid    (dec_valid),
    .dec_ready    (dec_ready),
    .dec          (dec),
    .res_valid_in (res_valid_in),
    .res_ready    (res_ready),
    .ex_out       (ex_out)
  );

  result_stage result_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .res_valid_in  (res_valid_in),
    .res_ready     (res_ready),
    .ex_out        (ex_out),
    .ret_valid     (ret_valid),
    .ret_ready     (ret_ready),
    .ret           (ret),
    .wr_en         (rf_wr_en),
    .wr_idx        (rf_wr_idx),
    .wr_data       (rf_wr_data),
    .res_fwd_valid (res_fwd_valid),
    .res_fwd       (res_fwd)
  );

  reg_file reg_file_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_idx_a  (rf_idx_a),
    .rd_idx_b  (rf_idx_b),
    .rd_data_a (rf_data_a),
    .rd_data_b (rf_data_b),
    .wr_en     (rf_wr_en),
    .wr_idx    (rf_wr_idx),
    .wr_data   (rf_wr_data)
  );

endmodule

// File: src/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int xlen  = 32;
  localparam int nregs = 32;

  typedef logic [4:0]      reg_idx_t;
  typedef logic [xlen-1:0] word_t;

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,  // register-register alu
    opc_op_imm = 7'b0010011,  // register-immediate alu
    opc_lui    = 7'b0110111
  } opcode_e;

  // funct3 codes of the integer alu group
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // alt selects sub and sra
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;

  // R format, also the view used for shift-immediates
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;  // sign bit at [11]
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0] imm;  // upper 20 bits of the result
    reg_idx_t    rd;
    opcode_e     opcode;
  } u_fmt_t;

  // one instruction word, three ways to look at it
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    u_fmt_t u;
  } inst_u;

endpackage
